/* tests/lsq_cases.txt */
// op addr data be fn3 id flag; op 1 load, 2 store, 3 retire, 4 stall, 5 unstall, 6 drain, 7 check
// load flag 1 expects the load ahead of its older stores; check flag is the expected req_ready
2 00000010 11111111 f 0 1 0
2 00000020 22222222 3 0 2 0
1 00000010 00000000 0 2 3 0
3 00000000 00000000 0 0 0 0
3 00000000 00000000 0 0 0 0
6 00000000 00000000 0 0 0 0
2 00000030 33333333 f 0 4 0
1 00000040 00000000 0 2 5 1
3 00000000 00000000 0 0 0 0
6 00000000 00000000 0 0 0 0
2 00000114 44444444 c 0 6 0
1 00000010 00000000 0 4 7 0
1 00000050 00000000 0 0 8 0
3 00000000 00000000 0 0 0 0
6 00000000 00000000 0 0 0 0
4 00000000 00000000 0 0 0 0
2 00000060 a5a5a5a5 f 0 9 0
2 00000064 5a5a5a5a 1 0 a 0
2 00000068 0f0f0f0f 2 0 b 0
2 0000006c f0f0f0f0 4 0 c 0
7 00000000 00000000 0 0 0 0
3 00000000 00000000 0 0 0 0
3 00000000 00000000 0 0 0 0
3 00000000 00000000 0 0 0 0
3 00000000 00000000 0 0 0 0
5 00000000 00000000 0 0 0 0
6 00000000 00000000 0 0 0 0
4 00000000 00000000 0 0 0 0
1 00000080 00000000 0 2 d 0
1 00000084 00000000 0 1 e 0
1 00000088 00000000 0 0 f 0
1 0000008c 00000000 0 4 0 0
1 00000090 00000000 0 5 1 0
1 00000094 00000000 0 2 2 0
1 00000098 00000000 0 2 3 0
1 0000009c 00000000 0 1 4 0
1 000000a0 00000000 0 2 5 0
7 00000000 00000000 0 0 0 0
5 00000000 00000000 0 0 0 0
6 00000000 00000000 0 0 0 0
0 00000000 00000000 0 0 0 0

/* files.f */
logic/lsq_pkg.sv
logic/lsq_fifo.sv
logic/store_queue.sv
logic/load_store_queue.sv
logic/mem_issue.sv
logic/lsq_unit.sv
tests/lsq_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := lsq_tb
FILELIST := files.f

BUILD    := obj_dir
SOURCES  := $(shell cat $(FILELIST))
BIN      := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD)

/* tests/lsq_tb.sv */
// Run from the project root; ops run one at a time, the hash model assumes HASH_W is 6
module lsq_tb;

    localparam int WORDS_PER_LINE = 7;
    localparam int MAX_LINES = 64;
    localparam int CYCLES_PER_LINE = 40;
    localparam int unsigned SEED = 32'hc98ee4f8;

    logic clk = 1'b0;
    logic rst;
    lsq_pkg::lsq_req_t req;
    logic req_valid;
    logic req_ready;
    logic store_retire;
    lsq_pkg::mem_req_t mem_req;
    logic mem_valid;
    logic mem_ready;

    // Case file with seven hex words per line
    logic [31:0] case_words [0:WORDS_PER_LINE*MAX_LINES-1];

    //////////////////////////////
    // Scoreboard state

    // Program order of outstanding operations
    lsq_pkg::mem_req_t exp_load [$];
    lsq_pkg::mem_req_t exp_store [$];
    int load_older [$];
    logic load_coll [$];
    logic load_pass [$];
    // Hash of every accepted store by store number
    logic [lsq_pkg::HASH_W-1:0] store_hash [$];
    int stores_accepted = 0;
    int stores_sent = 0;
    int retires = 0;
    int cycles = 0;
    int cycle_limit = 0;
    int n_lines = 0;
    // Forces mem_ready low
    logic hold_low = 1'b0;
    // Memory port as seen one cycle back
    logic last_valid = 1'b0;
    logic last_ready = 1'b0;
    lsq_pkg::mem_req_t last_req;

    lsq_unit dut (
        .clk(clk),
        .rst(rst),
        .req(req),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .store_retire(store_retire),
        .mem_req(mem_req),
        .mem_valid(mem_valid),
        .mem_ready(mem_ready)
    );

    always #2 clk = ~clk;

    //////////////////////////////
    // Reporting and compares

    task automatic report_error(input string msg);
        $display("** Error @ %0t: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopped on failure");
    endtask

    task automatic check_flag(input logic exp, input logic act, input string what);
        if (act !== exp) begin
            report_error($sformatf("%s expected %b got %b", what, exp, act));
        end
    endtask

    // Stores carry be and data, loads carry fn3
    task automatic check_mem_req(input lsq_pkg::mem_req_t exp, input lsq_pkg::mem_req_t act,
                                 input string what);
        logic bad;
        string exp_text;
        string act_text;
        bad = (act.addr !== exp.addr) || (act.we !== exp.we) || (act.id !== exp.id);
        if (exp.we) begin
            bad = bad || (act.be !== exp.be) || (act.wdata !== exp.wdata);
        end else begin
            bad = bad || (act.fn3 !== exp.fn3);
        end
        if (bad) begin
            exp_text = $sformatf("addr %h we %b be %h wdata %h fn3 %0d id %0d",
                exp.addr, exp.we, exp.be, exp.wdata, exp.fn3, exp.id);
            act_text = $sformatf("addr %h we %b be %h wdata %h fn3 %0d id %0d",
                act.addr, act.we, act.be, act.wdata, act.fn3, act.id);
            report_error({what, " expected ", exp_text, ", got ", act_text});
        end
    endtask

    // Word address split into 6 bit chunks and XORed
    function automatic logic [lsq_pkg::HASH_W-1:0] fold_hash(input logic [31:0] addr);
        logic [29:0] word;
        word = addr[31:2];
        return word[5:0] ^ word[11:6] ^ word[17:12] ^ word[23:18] ^ word[29:24];
    endfunction

    //////////////////////////////
    // Memory port monitor

    task automatic record_transfer(input lsq_pkg::mem_req_t got);
        lsq_pkg::mem_req_t exp;
        int older;
        logic coll;
        logic pass_flag;
        if (got.we) begin
            if (exp_store.size() == 0) stop_run("A store reached memory with none outstanding");
            if (stores_sent >= retires) stop_run("A store reached memory before its retire pulse");
            exp = exp_store.pop_front();
            check_mem_req(exp, got, "store request");
            stores_sent++;
        end else begin
            if (exp_load.size() == 0) stop_run("A load reached memory with none outstanding");
            exp = exp_load.pop_front();
            older = load_older.pop_front();
            coll = load_coll.pop_front();
            pass_flag = load_pass.pop_front();
            if (coll && (stores_sent < older)) begin
                stop_run("A load with a store hash match went out ahead of an older store");
            end
            if (pass_flag && (stores_sent >= older)) begin
                stop_run("A load without a hash match did not pass its unreleased stores");
            end
            check_mem_req(exp, got, "load request");
        end
    endtask

    // Waits one falling edge, checks the edge just passed and sets mem_ready
    task automatic step_cycle();
        @(negedge clk);
        cycles++;
        if (cycles > cycle_limit) begin
            stop_run($sformatf("Timed out after %0d cycles waiting on the DUT", cycles));
        end
        if (last_valid && last_ready) begin
            record_transfer(last_req);
        end else if (last_valid) begin
            // Stalled request must hold
            check_flag(1'b1, mem_valid, "mem_valid while stalled");
            check_mem_req(last_req, mem_req, "mem_req while stalled");
        end
        if (hold_low) begin
            mem_ready = 1'b0;
        end else begin
            mem_ready = ($urandom % 4) != 0;
        end
        last_valid = mem_valid;
        last_ready = mem_ready;
        last_req = mem_req;
    endtask

    //////////////////////////////
    // Stimulus

    task automatic drive_request(input int b, input logic is_load);
        lsq_pkg::mem_req_t exp;
        logic [lsq_pkg::HASH_W-1:0] h;
        int departed;
        logic coll;
        while (!req_ready) step_cycle();
        req.addr = case_words[b + 1];
        req.data = case_words[b + 2];
        req.be = case_words[b + 3][3:0];
        req.fn3 = case_words[b + 4][2:0];
        req.id = case_words[b + 5][lsq_pkg::ID_W-1:0];
        req.load = is_load;
        req.store = !is_load;
        req_valid = 1'b1;
        h = fold_hash(req.addr);
        exp = '{addr: req.addr, we: !is_load, be: req.be, wdata: req.data, fn3: req.fn3,
                id: is_load ? req.id : '0};
        if (is_load) begin
            // Stores already in the issue register or gone are not pending
            departed = stores_sent + ((mem_valid && mem_req.we) ? 1 : 0);
            coll = 1'b0;
            for (int i = departed; i < stores_accepted; i++) begin
                if (store_hash[i] == h) coll = 1'b1;
            end
            exp_load.push_back(exp);
            load_older.push_back(stores_accepted);
            load_coll.push_back(coll);
            load_pass.push_back(case_words[b + 6][0]);
        end else begin
            exp_store.push_back(exp);
            store_hash.push_back(h);
            stores_accepted++;
        end
        step_cycle();
        req_valid = 1'b0;
    endtask

    task automatic pulse_retire();
        store_retire = 1'b1;
        step_cycle();
        store_retire = 1'b0;
        retires++;
    endtask

    task automatic drain_queues();
        while ((exp_load.size() != 0) || (exp_store.size() != 0)) step_cycle();
    endtask

    // Op codes are 1 load, 2 store, 3 retire, 4 stall, 5 unstall, 6 drain, 7 check req_ready
    task automatic run_case_line(input int b);
        int op;
        op = int'(case_words[b]);
        case (op)
            1: drive_request(b, 1'b1);
            2: drive_request(b, 1'b0);
            3: pulse_retire();
            4: begin
                hold_low = 1'b1;
                step_cycle();
            end
            5: begin
                hold_low = 1'b0;
                step_cycle();
            end
            6: drain_queues();
            7: check_flag(case_words[b + 6][0], req_ready, "req_ready");
            default: stop_run($sformatf("Unknown op %0d in the case file", op));
        endcase
    endtask

    initial begin
        rst = 1'b1;
        req = '0;
        req_valid = 1'b0;
        store_retire = 1'b0;
        mem_ready = 1'b0;
        void'($urandom(SEED));
        $readmemh("tests/lsq_cases.txt", case_words);
        // Op zero ends the list
        while ((n_lines < MAX_LINES) && (case_words[n_lines*WORDS_PER_LINE] !== 32'h0)) begin
            n_lines++;
        end
        if (n_lines == MAX_LINES) stop_run("The case file has no end marker");
        cycle_limit = n_lines * CYCLES_PER_LINE;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_flag(1'b0, mem_valid, "mem_valid after reset");
        check_flag(1'b1, req_ready, "req_ready after reset");
        for (int line = 0; line < n_lines; line++) begin
            run_case_line(line * WORDS_PER_LINE);
        end
        if ((exp_load.size() == 0) && (exp_store.size() == 0)) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("Operations were still outstanding at the end of the cases");
            $display("RESULT: FAIL");
            $fatal(1, "outstanding operations");
        end
    end

endmodule

/* logic/lsq_unit.sv */
// LSQ top; store_retire pulses one cycle per store, mem port follows valid/ready
module lsq_unit (
    input logic clk,
    input logic rst,
    // Core side
    input lsq_pkg::lsq_req_t req,
    input logic req_valid,
    output logic req_ready,
    input logic store_retire,
    // Memory side
    output lsq_pkg::mem_req_t mem_req,
    output logic mem_valid,
    input logic mem_ready
);
    logic load_valid;
    logic load_pop;
    logic store_valid;
    logic store_pop;
    lsq_pkg::mem_req_t load_req;
    lsq_pkg::mem_req_t store_req;

    // Queues
    load_store_queue lsq (
        .clk(clk),
        .rst(rst),
        .req(req),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .store_retire(store_retire),
        .load_valid(load_valid),
        .load_req(load_req),
        .load_pop(load_pop),
        .store_valid(store_valid),
        .store_req(store_req),
        .store_pop(store_pop)
    );

    // Issue stage
    mem_issue issue (
        .clk(clk),
        .rst(rst),
        .load_valid(load_valid),
        .load_req(load_req),
        .load_pop(load_pop),
        .store_valid(store_valid),
        .store_req(store_req),
        .store_pop(store_pop),
        .mem_req(mem_req),
        .mem_valid(mem_valid),
        .mem_ready(mem_ready)
    );

endmodule

/* logic/mem_issue.sv */
// One-entry issue register; loads win over stores, request holds while mem_ready is low
module mem_issue (
    input logic clk,
    input logic rst,
    input logic load_valid,
    input lsq_pkg::mem_req_t load_req,
    output logic load_pop,
    input logic store_valid,
    input lsq_pkg::mem_req_t store_req,
    output logic store_pop,
    output lsq_pkg::mem_req_t mem_req,
    output logic mem_valid,
    input logic mem_ready
);
    // Register free now or emptying this edge
    logic can_fill;

    assign can_fill = !mem_valid || mem_ready;

    //////////////////////////////
    // Select

    // Loads first and a store only when no load is ready
    assign load_pop = can_fill && load_valid;
    assign store_pop = can_fill && !load_valid && store_valid;

    //////////////////////////////
    // Output register

    // Payload written only on a pop
    always_ff @(posedge clk) begin
        if (load_pop) begin
            mem_req <= load_req;
        end else if (store_pop) begin
            mem_req <= store_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid <= 1'b0;
        end else if (can_fill) begin
            mem_valid <= load_pop || store_pop;
        end
    end

    // Unpopped load waits at the queue head unchanged
    load_held: assert property (@(posedge clk) disable iff (rst)
        (load_valid && !load_pop) |=> (load_valid && $stable(load_req)));

endmodule

/* logic/load_store_queue.sv */
// Splits requests into load FIFO and store queue; one request per cycle, no flush, no forwarding
module load_store_queue (
    input logic clk,
    input logic rst,
    input lsq_pkg::lsq_req_t req,
    input logic req_valid,
    output logic req_ready,
    input logic store_retire,
    output logic load_valid,
    output lsq_pkg::mem_req_t load_req,
    input logic load_pop,
    output logic store_valid,
    output lsq_pkg::mem_req_t store_req,
    input logic store_pop
);
    logic accept;
    logic lq_valid;
    logic lq_full;
    logic sq_full;
    logic collision;
    logic load_blocked;
    lsq_pkg::sq_idx_t sq_write_idx;
    lsq_pkg::sq_idx_t sq_oldest_idx;
    lsq_pkg::lq_entry_t lq_in;
    lsq_pkg::lq_entry_t lq_out;
    lsq_pkg::sq_entry_t sq_in;
    lsq_pkg::sq_entry_t sq_head;

    //////////////////////////////
    // Accept

    // Either queue full stalls every request
    assign req_ready = !lq_full && !sq_full;
    assign accept = req_valid && req_ready;

    //////////////////////////////
    // Load queue

    // Tag with collision state at accept time
    assign lq_in = '{
        addr: req.addr,
        fn3: req.fn3,
        id: req.id,
        store_collision: collision,
        sq_idx: sq_write_idx
    };

    lsq_fifo #(.DEPTH(lsq_pkg::LQ_DEPTH)) load_fifo (
        .clk(clk),
        .rst(rst),
        .push(accept && req.load),
        .pop(load_pop),
        .data_in(lq_in),
        .data_out(lq_out),
        .valid(lq_valid),
        .full(lq_full)
    );

    //////////////////////////////
    // Store queue

    assign sq_in = '{addr: req.addr, be: req.be, data: req.data};

    store_queue sq_block (
        .clk(clk),
        .rst(rst),
        .push(accept && req.store),
        .entry(sq_in),
        .pop(store_pop),
        .retire(store_retire),
        .load_addr(req.addr),
        .collision(collision),
        .write_idx(sq_write_idx),
        .oldest_idx(sq_oldest_idx),
        .head(sq_head),
        .valid(store_valid),
        .full(sq_full)
    );

    //////////////////////////////
    // Outputs

    // Held until every store older than the load has been popped
    assign load_blocked = lq_out.store_collision && (lq_out.sq_idx != sq_oldest_idx);
    assign load_valid = lq_valid && !load_blocked;

    // Load view without write payload
    assign load_req = '{
        addr: lq_out.addr,
        we: 1'b0,
        be: 4'b0000,
        wdata: 32'h0,
        fn3: lq_out.fn3,
        id: lq_out.id
    };

    // Store view with width carried by byte enables
    assign store_req = '{
        addr: sq_head.addr,
        we: 1'b1,
        be: sq_head.be,
        wdata: sq_head.data,
        fn3: 3'b000,
        id: '0
    };

endmodule

/* logic/store_queue.sv */
// Store buffer; one push per cycle, retire must follow the push of its store, pops only released
module store_queue (
    input logic clk,
    input logic rst,
    input logic push,
    input lsq_pkg::sq_entry_t entry,
    input logic pop,
    input logic retire,
    input logic [31:0] load_addr,
    output logic collision,
    output lsq_pkg::sq_idx_t write_idx,
    output lsq_pkg::sq_idx_t oldest_idx,
    output lsq_pkg::sq_entry_t head,
    output logic valid,
    output logic full
);
    //////////////////////////////
    // State

    // Payload and address hashes per slot
    lsq_pkg::sq_entry_t entries [lsq_pkg::SQ_DEPTH];
    logic [lsq_pkg::HASH_W-1:0] hashes [lsq_pkg::SQ_DEPTH];

    // Slots between oldest and write
    logic [lsq_pkg::SQ_DEPTH-1:0] occupied;
    logic [lsq_pkg::SQ_DEPTH-1:0] hash_hit;

    // Next store to be released by retire
    lsq_pkg::sq_idx_t release_idx;

    logic [lsq_pkg::SQ_IDX_W-2:0] write_slot;
    logic [lsq_pkg::SQ_IDX_W-2:0] oldest_slot;
    logic [lsq_pkg::HASH_W-1:0] load_hash;

    // Fold word address bits 31..2 down to HASH_W bits
    function automatic logic [lsq_pkg::HASH_W-1:0] addr_hash(input logic [31:0] addr);
        logic [lsq_pkg::HASH_W-1:0] h;
        h = '0;
        for (int i = 2; i < 32; i++) begin
            h[(i - 2) % lsq_pkg::HASH_W] ^= addr[i];
        end
        return h;
    endfunction

    assign write_slot = write_idx[lsq_pkg::SQ_IDX_W-2:0];
    assign oldest_slot = oldest_idx[lsq_pkg::SQ_IDX_W-2:0];

    //////////////////////////////
    // Entry storage

    // Hash taken once at write time
    always_ff @(posedge clk) begin
        if (push) begin
            entries[write_slot] <= entry;
            hashes[write_slot] <= addr_hash(entry.addr);
        end
    end

    //////////////////////////////
    // Pointers

    always_ff @(posedge clk) begin
        if (rst) begin
            write_idx <= '0;
            release_idx <= '0;
            oldest_idx <= '0;
            occupied <= '0;
        end else begin
            if (push) begin
                write_idx <= write_idx + lsq_pkg::sq_idx_t'(1);
            end
            if (retire) begin
                release_idx <= release_idx + lsq_pkg::sq_idx_t'(1);
            end
            if (pop) begin
                oldest_idx <= oldest_idx + lsq_pkg::sq_idx_t'(1);
            end
            // Push and pop never hit the same slot in one cycle
            for (int i = 0; i < lsq_pkg::SQ_DEPTH; i++) begin
                if (pop && (32'(oldest_slot) == i)) begin
                    occupied[i] <= 1'b0;
                end else if (push && (32'(write_slot) == i)) begin
                    occupied[i] <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // Collision check

    assign load_hash = addr_hash(load_addr);

    // Released but unsent stores still count
    always_comb begin
        for (int i = 0; i < lsq_pkg::SQ_DEPTH; i++) begin
            hash_hit[i] = occupied[i] && (hashes[i] == load_hash);
        end
    end

    assign collision = |hash_hit;

    //////////////////////////////
    // Outputs

    assign head = entries[oldest_slot];
    // Oldest store already released
    assign valid = (oldest_idx != release_idx);
    // Same slot with the opposite wrap bit
    assign full = (write_slot == oldest_slot)
        && (write_idx[lsq_pkg::SQ_IDX_W-1] != oldest_idx[lsq_pkg::SQ_IDX_W-1]);

    // Retire pulse needs a stored, unreleased store behind it
    release_behind_write: assert property (@(posedge clk) disable iff (rst)
        retire |-> (release_idx != write_idx));

endmodule

/* logic/lsq_fifo.sv */
// Load entry FIFO; caller must never push when full or pop when empty, no flush
module lsq_fifo #(
    parameter int DEPTH = lsq_pkg::LQ_DEPTH
) (
    input logic clk,
    input logic rst,
    input logic push,
    input logic pop,
    input lsq_pkg::lq_entry_t data_in,
    output lsq_pkg::lq_entry_t data_out,
    output logic valid,
    output logic full
);
    // Entry storage
    lsq_pkg::lq_entry_t mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;

    // Write side
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (32'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (32'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head is always visible
    assign data_out = mem[rd_ptr];
    assign valid = (count != '0);
    assign full = (32'(count) == DEPTH);

    // Overflow and underflow guards
    no_push_full: assert property (@(posedge clk) disable iff (rst) !(push && full));
    no_pop_empty: assert property (@(posedge clk) disable iff (rst) !(pop && !valid));

endmodule

/* logic/lsq_pkg.sv */
// Shared LSQ definitions; SQ_DEPTH must stay a power of two, ids are 4 bits, store ids read as zero
package lsq_pkg;

    //////////////////////////////
    // Sizes

    // Load queue holds one entry per id in flight
    localparam int LQ_DEPTH = 8;
    // Power of two so pointer wrap is free
    localparam int SQ_DEPTH = 4;
    // Slot bits plus one wrap bit
    localparam int SQ_IDX_W = $clog2(SQ_DEPTH) + 1;
    localparam int ID_W = 4;
    // XOR fold of word address bits 31..2
    localparam int HASH_W = 6;

    //////////////////////////////
    // Types

    typedef logic [ID_W-1:0] id_t;
    typedef logic [SQ_IDX_W-1:0] sq_idx_t;

    // Request as issued by the core
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0] fn3;
        logic load;
        logic store;
        logic [3:0] be;
        logic [31:0] data;
        id_t id;
    } lsq_req_t;

    // Load queue entry
    // Collision tag is the store write position seen at accept
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0] fn3;
        id_t id;
        logic store_collision;
        sq_idx_t sq_idx;
    } lq_entry_t;

    // Store queue payload carrying its own data
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0] be;
        logic [31:0] data;
    } sq_entry_t;

    // Request on the data memory port
    typedef struct packed {
        logic [31:0] addr;
        logic we;
        logic [3:0] be;
        logic [31:0] wdata;
        logic [2:0] fn3;
        // Zero for stores
        id_t id;
    } mem_req_t;

endpackage
